//--- source/routing_pkg.sv
package routing_pkg;

	// plain vector types with a meaning
	typedef logic [15:0] word_t;
	typedef logic [15:0] address_t;
	typedef logic [15:0] node_id_t;
	// unsigned fixed point, compared as an integer
	typedef logic [15:0] q_value_t;
	// 0 to 64 needs seven bits
	typedef logic [6:0] count_t;

	// byte array geometry
	localparam int mem_depth = 2048;
	localparam int mem_width = 8;
	localparam int mem_address_width = 11;

	// node memory map, byte addresses of 16-bit words
	localparam address_t neighbor_id_base = 16'h0048;
	localparam address_t cluster_id_base = 16'h00C8;
	localparam address_t q_value_base = 16'h01C8;
	localparam address_t neighbor_count_addr = 16'h068A;

	// table and input buffer limits
	localparam int max_neighbors = 64;
	localparam int report_depth = 4;
	localparam int report_pointer_width = 2;

	// one incoming strobe, report or query
	typedef struct packed {
		// only this field counts for a query
		logic is_query;
		node_id_t neighbor_id;
		node_id_t cluster_id;
		q_value_t q_value;
	} neighbor_report_t;

	// one table entry streamed during a scan
	typedef struct packed {
		node_id_t neighbor_id;
		node_id_t cluster_id;
		q_value_t q_value;
		// final entry of the scan
		logic last;
	} table_entry_t;

	// answer to a route query
	typedef struct packed {
		// clear when the table was empty
		logic found;
		node_id_t best_id;
		q_value_t best_q;
		count_t cluster_members;
	} route_result_t;

	// table manager states
	typedef enum logic [3:0] {
		clear,
		idle,
		read_count,
		search,
		update,
		append,
		bump_count,
		scan,
		finish
	} manager_state_t;

endpackage

//--- source/report_receiver.sv
module report_receiver (
	input logic clock,
	input logic reset,
	input logic report_strobe,
	input routing_pkg::neighbor_report_t report,
	input logic take,
	output logic pending,
	output routing_pkg::neighbor_report_t head,
	output logic report_dropped
);
	import routing_pkg::*;

	// circular buffer storage, payload only
	neighbor_report_t buffer [report_depth];

	logic [report_pointer_width-1:0] write_pointer;
	logic [report_pointer_width-1:0] read_pointer;
	// one extra bit so four entries fit
	logic [report_pointer_width:0] occupancy;

	logic full;
	logic pop;
	logic push;

	assign full = (occupancy == (report_pointer_width + 1)'(report_depth));
	assign pop = take && pending;
	// a full buffer still takes a strobe when the head leaves in the same cycle
	assign push = report_strobe && (!full || pop);

	assign pending = (occupancy != '0);
	assign head = buffer[read_pointer];

	// store incoming report at the tail
	always_ff @(posedge clock) begin
		if (push) begin
			buffer[write_pointer] <= report;
		end
	end

	// pointers, fill level and drop flag
	always_ff @(posedge clock) begin
		if (reset) begin
			write_pointer <= '0;
			read_pointer <= '0;
			occupancy <= '0;
			report_dropped <= 1'b0;
		end else begin
			// flag lands one cycle after the lost strobe
			report_dropped <= report_strobe && !push;
			if (push) begin
				// wraps naturally at four
				write_pointer <= write_pointer + 1'b1;
			end
			if (pop) begin
				read_pointer <= read_pointer + 1'b1;
			end
			case ({push, pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				// both or neither, level unchanged
				default: occupancy <= occupancy;
			endcase
		end
	end

endmodule

//--- source/node_memory.sv
module node_memory (
	input logic clock,
	input routing_pkg::address_t address,
	input logic write_enable,
	input routing_pkg::word_t write_data,
	output routing_pkg::word_t read_data
);
	import routing_pkg::*;

	// byte array, contents undefined until written
	logic [mem_width-1:0] memory [mem_depth];

	// low byte of the word sits one address up
	address_t next_address;
	logic [mem_address_width-1:0] high_index;
	logic [mem_address_width-1:0] low_index;

	assign next_address = address + address_t'(1);

	// only the bottom of the 16-bit address reaches the array
	assign high_index = address[mem_address_width-1:0];
	assign low_index = next_address[mem_address_width-1:0];

	// big-endian word read, no clock
	assign read_data = {memory[high_index], memory[low_index]};

	// both bytes written at the same edge
	always_ff @(posedge clock) begin
		if (write_enable) begin
			memory[high_index] <= write_data[2*mem_width-1:mem_width];
			memory[low_index] <= write_data[mem_width-1:0];
		end
	end

endmodule

//--- source/table_manager.sv
module table_manager (
	input logic clock,
	input logic reset,
	input logic pending,
	input routing_pkg::neighbor_report_t head,
	input routing_pkg::word_t read_data,
	output logic take,
	output routing_pkg::address_t address,
	output logic write_enable,
	output routing_pkg::word_t write_data,
	output logic entry_strobe,
	output routing_pkg::table_entry_t entry,
	output logic scan_empty,
	output logic active
);
	import routing_pkg::*;

	manager_state_t state;

	// command being worked on
	neighbor_report_t command;
	// table size read at the start of each command
	count_t count;
	count_t index;
	// word within an entry: 0 id, 1 cluster, 2 q
	logic [1:0] field;

	// id and cluster held until the q word arrives
	node_id_t scan_id;
	node_id_t scan_cluster;

	count_t stored_count;
	count_t next_count;
	logic last_index;
	logic id_match;
	address_t region_base;
	address_t entry_offset;
	address_t entry_address;

	// count word keeps its value in the low bits
	assign stored_count = read_data[$bits(count_t)-1:0];
	assign next_count = count + count_t'(1);
	assign last_index = ((index + count_t'(1)) == count);
	assign id_match = (read_data == command.neighbor_id);

	// two bytes per entry
	assign entry_offset = {{($bits(address_t) - $bits(count_t) - 1){1'b0}}, index, 1'b0};

	always_comb begin
		case (field)
			2'd0: region_base = neighbor_id_base;
			2'd1: region_base = cluster_id_base;
			default: region_base = q_value_base;
		endcase
	end

	assign entry_address = region_base + entry_offset;

	// entry states walk the regions, the rest sit on the count word
	assign address = (state == search || state == update || state == append ||
		state == scan) ? entry_address : neighbor_count_addr;

	assign write_enable = (state == clear || state == update || state == append ||
		state == bump_count);

	always_comb begin
		case (state)
			bump_count: write_data = {{($bits(word_t) - $bits(count_t)){1'b0}}, next_count};
			update, append: begin
				case (field)
					2'd0: write_data = command.neighbor_id;
					2'd1: write_data = command.cluster_id;
					default: write_data = command.q_value;
				endcase
			end
			// clear writes a zero count
			default: write_data = '0;
		endcase
	end

	assign take = (state == idle) && pending;
	assign active = (state != idle);

	// query against an empty table
	assign scan_empty = (state == read_count) && command.is_query && (stored_count == '0);

	// q word read completes the entry
	assign entry_strobe = (state == scan) && (field == 2'd2);
	assign entry = '{
		neighbor_id: scan_id,
		cluster_id: scan_cluster,
		q_value: read_data,
		last: last_index
	};

	// payload captures
	always_ff @(posedge clock) begin
		if (take) begin
			command <= head;
		end
		if (state == scan && field == 2'd0) begin
			scan_id <= read_data;
		end
		if (state == scan && field == 2'd1) begin
			scan_cluster <= read_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= clear;
			count <= '0;
			index <= '0;
			field <= '0;
		end else begin
			case (state)
				clear: state <= idle;
				idle: begin
					if (pending) begin
						state <= read_count;
					end
				end
				read_count: begin
					count <= stored_count;
					index <= '0;
					field <= '0;
					if (command.is_query) begin
						state <= (stored_count == '0) ? finish : scan;
					end else if (stored_count == '0) begin
						state <= append;
					end else begin
						state <= search;
					end
				end
				search: begin
					if (id_match) begin
						// known neighbor, rewrite cluster and q only
						field <= 2'd1;
						state <= update;
					end else if (last_index) begin
						if (count < count_t'(max_neighbors)) begin
							index <= count;
							state <= append;
						end else begin
							// table full, report ignored
							state <= finish;
						end
					end else begin
						index <= index + count_t'(1);
					end
				end
				update: begin
					if (field == 2'd2) begin
						state <= finish;
					end else begin
						field <= field + 1'b1;
					end
				end
				append: begin
					if (field == 2'd2) begin
						field <= '0;
						state <= bump_count;
					end else begin
						field <= field + 1'b1;
					end
				end
				bump_count: state <= finish;
				scan: begin
					if (field == 2'd2) begin
						field <= '0;
						if (last_index) begin
							state <= finish;
						end else begin
							index <= index + count_t'(1);
						end
					end else begin
						field <= field + 1'b1;
					end
				end
				finish: state <= idle;
				default: state <= idle;
			endcase
		end
	end

endmodule

//--- source/route_reporter.sv
module route_reporter (
	input logic clock,
	input logic reset,
	input routing_pkg::node_id_t my_cluster,
	input logic entry_strobe,
	input routing_pkg::table_entry_t entry,
	input logic scan_empty,
	output logic result_strobe,
	output routing_pkg::route_result_t result
);
	import routing_pkg::*;

	// running accumulators over one scan
	logic seen;
	node_id_t best_id;
	q_value_t best_q;
	count_t members;

	logic next_seen;
	logic take_entry;
	logic in_cluster;
	logic done;
	node_id_t next_best_id;
	q_value_t next_best_q;
	count_t next_members;

	assign next_seen = seen || entry_strobe;
	// strictly greater, so the earliest entry keeps a tie
	assign take_entry = entry_strobe && (!seen || entry.q_value > best_q);
	assign in_cluster = entry_strobe && (entry.cluster_id == my_cluster);

	assign next_best_id = take_entry ? entry.neighbor_id : best_id;
	assign next_best_q = take_entry ? entry.q_value : best_q;
	assign next_members = members + count_t'(in_cluster);

	assign done = (entry_strobe && entry.last) || scan_empty;

	always_ff @(posedge clock) begin
		best_id <= next_best_id;
		best_q <= next_best_q;
		if (done) begin
			result.found <= next_seen;
			// zeros rather than stale values for an empty table
			result.best_id <= next_seen ? next_best_id : '0;
			result.best_q <= next_seen ? next_best_q : '0;
			result.cluster_members <= next_members;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			seen <= 1'b0;
			members <= '0;
			result_strobe <= 1'b0;
		end else begin
			result_strobe <= done;
			// ready for the next scan
			seen <= done ? 1'b0 : next_seen;
			members <= done ? '0 : next_members;
		end
	end

endmodule

//--- source/routing_engine.sv
module routing_engine (
	input logic clock,
	input logic reset,
	input logic report_strobe,
	input routing_pkg::neighbor_report_t report,
	input routing_pkg::node_id_t my_cluster,
	output logic report_dropped,
	output logic busy,
	output logic result_strobe,
	output routing_pkg::route_result_t result
);
	import routing_pkg::*;

	// receiver to manager
	logic pending;
	neighbor_report_t head;
	logic take;

	// manager to memory
	address_t address;
	logic write_enable;
	word_t write_data;
	word_t read_data;

	// manager to reporter
	logic entry_strobe;
	table_entry_t entry;
	logic scan_empty;
	logic active;

	// work queued or in progress
	assign busy = pending || active;

	report_receiver receiver0 (
		.clock(clock),
		.reset(reset),
		.report_strobe(report_strobe),
		.report(report),
		.take(take),
		.pending(pending),
		.head(head),
		.report_dropped(report_dropped)
	);

	table_manager manager0 (
		.clock(clock),
		.reset(reset),
		.pending(pending),
		.head(head),
		.read_data(read_data),
		.take(take),
		.address(address),
		.write_enable(write_enable),
		.write_data(write_data),
		.entry_strobe(entry_strobe),
		.entry(entry),
		.scan_empty(scan_empty),
		.active(active)
	);

	node_memory memory0 (
		.clock(clock),
		.address(address),
		.write_enable(write_enable),
		.write_data(write_data),
		.read_data(read_data)
	);

	route_reporter reporter0 (
		.clock(clock),
		.reset(reset),
		.my_cluster(my_cluster),
		.entry_strobe(entry_strobe),
		.entry(entry),
		.scan_empty(scan_empty),
		.result_strobe(result_strobe),
		.result(result)
	);

endmodule

//--- tb/routing_engine_tb.sv
module routing_engine_tb;
	import routing_pkg::*;

	// run budget, 90 reports and 9 queries over all tests
	localparam int report_total = 90;
	localparam int query_total = 9;
	localparam int cycle_limit = 400 * report_total + 250 * query_total;

	logic clock;
	logic reset;
	logic report_strobe;
	neighbor_report_t report;
	node_id_t my_cluster;
	logic report_dropped;
	logic busy;
	logic result_strobe;
	route_result_t result;

	// reference neighbor table
	node_id_t model_id [max_neighbors];
	node_id_t model_cluster [max_neighbors];
	q_value_t model_q [max_neighbors];
	int model_count;

	route_result_t expected_results [$];

	integer seed;
	int error_count;
	int check_total;
	int cycle_count;
	int results_seen;
	int drop_total;
	// reports that reached the model
	int accepted_total;

	// strobe from one cycle back, its drop flag shows now
	logic strobe_delayed;
	neighbor_report_t report_delayed;

	routing_engine dut0 (
		.clock(clock),
		.reset(reset),
		.report_strobe(report_strobe),
		.report(report),
		.my_cluster(my_cluster),
		.report_dropped(report_dropped),
		.busy(busy),
		.result_strobe(result_strobe),
		.result(result)
	);

	always #50 clock = ~clock;

	// hit rewrites cluster and q, miss appends while room is left
	function automatic void model_update(neighbor_report_t r);
		int hit;
		hit = -1;
		for (int i = 0; i < model_count; i++) begin
			if (hit < 0 && model_id[i] == r.neighbor_id) begin
				hit = i;
			end
		end
		if (hit >= 0) begin
			model_cluster[hit] = r.cluster_id;
			model_q[hit] = r.q_value;
		end else if (model_count < max_neighbors) begin
			model_id[model_count] = r.neighbor_id;
			model_cluster[model_count] = r.cluster_id;
			model_q[model_count] = r.q_value;
			model_count++;
		end
	endfunction

	// highest q, first entry keeps a tie
	function automatic route_result_t best_route(node_id_t cluster);
		route_result_t r;
		int members;
		r = '0;
		members = 0;
		for (int i = 0; i < model_count; i++) begin
			if (i == 0 || model_q[i] > r.best_q) begin
				r.best_id = model_id[i];
				r.best_q = model_q[i];
			end
			if (model_cluster[i] == cluster) begin
				members++;
			end
		end
		r.found = (model_count > 0);
		r.cluster_members = count_t'(members);
		return r;
	endfunction

	function automatic q_value_t random_q();
		return q_value_t'($random(seed));
	endfunction

	// one of two clusters
	function automatic node_id_t random_cluster();
		int pick;
		pick = $random(seed);
		return pick[0] ? 16'h000A : 16'h000B;
	endfunction

	task automatic check_result(route_result_t got, route_result_t expected);
		check_total++;
		if (got !== expected) begin
			error_count++;
			$display("** Error result at %0t: got found %h id %h q %h members %h",
				$time, got.found, got.best_id, got.best_q, got.cluster_members);
			$display("   expected found %h id %h q %h members %h",
				expected.found, expected.best_id, expected.best_q, expected.cluster_members);
		end
	endtask

	task automatic check_count(string name, count_t got, count_t expected);
		check_total++;
		if (got !== expected) begin
			error_count++;
			$display("** Error %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic wait_idle();
		// strobe needs two edges to show up on busy
		repeat (2) @(negedge clock);
		while (busy) begin
			@(negedge clock);
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		model_count = 0;
		wait_idle();
	endtask

	task automatic set_cluster(node_id_t cluster);
		@(posedge clock);
		my_cluster <= cluster;
	endtask

	task automatic send_report(node_id_t id, node_id_t cluster, q_value_t q);
		@(posedge clock);
		report_strobe <= 1'b1;
		report <= '{is_query: 1'b0, neighbor_id: id, cluster_id: cluster, q_value: q};
		@(posedge clock);
		report_strobe <= 1'b0;
		wait_idle();
	endtask

	task automatic run_query();
		int target;
		target = results_seen + 1;
		@(posedge clock);
		report_strobe <= 1'b1;
		report <= '{is_query: 1'b1, neighbor_id: '0, cluster_id: '0, q_value: '0};
		@(posedge clock);
		report_strobe <= 1'b0;
		while (results_seen < target) begin
			@(negedge clock);
		end
		wait_idle();
	endtask

	// accepted strobes feed the model in arrival order
	always @(negedge clock) begin
		if (strobe_delayed && !report_dropped) begin
			if (report_delayed.is_query) begin
				expected_results.push_back(best_route(my_cluster));
			end else begin
				model_update(report_delayed);
				accepted_total++;
			end
		end
		strobe_delayed = report_strobe && !reset;
		report_delayed = report;
	end

	// every drop pulse counts, with or without a strobe before it
	always @(negedge clock) begin
		if (report_dropped === 1'b1) begin
			drop_total++;
		end
	end

	// every result against the oldest open query
	always @(negedge clock) begin
		if (!reset && result_strobe) begin
			if (expected_results.size() == 0) begin
				error_count++;
				$display("result strobe at %0t without an open query", $time);
			end else begin
				check_result(result, expected_results.pop_front());
			end
			results_seen++;
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout, run went past %0d cycles", cycle_limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		int drops_before;
		int accepted_before;
		clock = 1'b0;
		reset = 1'b1;
		report_strobe = 1'b0;
		report = '0;
		my_cluster = 16'h000A;
		seed = 16;
		error_count = 0;
		check_total = 0;
		cycle_count = 0;
		results_seen = 0;
		drop_total = 0;
		accepted_total = 0;
		model_count = 0;
		strobe_delayed = 1'b0;
		report_delayed = '0;

		apply_reset();

		// empty table
		run_query();

		// 0x0102 and 0x0103 tie on q
		send_report(16'h0101, 16'h000A, 16'h0300);
		send_report(16'h0102, 16'h000B, 16'h0500);
		send_report(16'h0103, 16'h000A, 16'h0500);
		send_report(16'h0104, 16'h000A, 16'h0200);
		run_query();

		// former best drops back, then another takes over
		send_report(16'h0102, 16'h000A, 16'h0100);
		run_query();
		send_report(16'h0101, 16'h000B, 16'h0600);
		run_query();

		// cluster count for both clusters
		for (int i = 0; i < 6; i++) begin
			send_report(16'h0200 + 16'(i), random_cluster(), random_q());
		end
		run_query();
		set_cluster(16'h000B);
		run_query();

		// 68 neighbors, the four past the limit hold the top q
		apply_reset();
		for (int i = 0; i < 68; i++) begin
			if (i < max_neighbors) begin
				send_report(16'h1000 + 16'(i), random_cluster(), random_q() & 16'h7FFF);
			end else begin
				send_report(16'h1000 + 16'(i), random_cluster(), 16'hFFFF);
			end
		end
		run_query();
		set_cluster(16'h000A);
		run_query();

		if (drop_total != 0) begin
			error_count++;
			$display("%0d spaced reports were dropped", drop_total);
		end

		// back-to-back burst into an empty table, all in our own cluster
		apply_reset();
		set_cluster(16'h000C);
		drops_before = drop_total;
		accepted_before = accepted_total;
		for (int i = 0; i < 10; i++) begin
			@(posedge clock);
			report_strobe <= 1'b1;
			report <= '{is_query: 1'b0, neighbor_id: 16'h2000 + 16'(i),
				cluster_id: 16'h000C, q_value: random_q()};
		end
		@(posedge clock);
		report_strobe <= 1'b0;
		wait_idle();
		run_query();
		// drop pulses against reports sent minus those the model took
		check_count("report_dropped", count_t'(drop_total - drops_before),
			count_t'(10 - (accepted_total - accepted_before)));
		if (drop_total == drops_before) begin
			error_count++;
			$display("burst of 10 reports produced no drops");
		end

		if (expected_results.size() != 0) begin
			error_count++;
			$display("%0d query results never arrived", expected_results.size());
		end

		$display("checks: %0d, errors: %0d", check_total, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- routing_engine.f
source/routing_pkg.sv
source/report_receiver.sv
source/node_memory.sv
source/table_manager.sv
source/route_reporter.sv
source/routing_engine.sv
tb/routing_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= routing_engine_tb
FILELIST ?= routing_engine.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
